// File: Makefile
SIM      := verilator
FLAGS    := --binary --timing -Wno-fatal
TOP      := tb_core
FILELIST := verilog.f
OBJ_DIR  := obj_dir

.PHONY: simulate clean

simulate:
	$(SIM) $(FLAGS) --top-module $(TOP) -f $(FILELIST) --Mdir $(OBJ_DIR)
	./$(OBJ_DIR)/V$(TOP)

clean:
	rm -rf $(OBJ_DIR)

// File: hdl/core.sv
`timescale 1ns/1ns
`default_nettype none
`include "core_settings.svh"

module core import core_pkg::*; (
    input  logic      clk,
    input  logic      resetn,
    input  logic      i_fetch_valid,
    input  fetch_t    i_fetch,
    output logic      o_fetch_ready,
    output wb_t       o_wb,
    output redirect_t o_redirect
);

    decoded_t         fetch_decoded;
    decoded_t         de_decoded;
    logic             de_valid;
    logic             ex_ready;
    logic [`XLEN-1:0] rs1_data;
    logic [`XLEN-1:0] rs2_data;
    wb_t              wb;

    insn_decoder decoder_inst (
        .i_fetch   (i_fetch),
        .o_decoded (fetch_decoded)
    );

    assign o_fetch_ready = ex_ready;

    ////////////////////////////////////////
    // DE register
    ////////////////////////////////////////

    always_ff @(posedge clk or negedge resetn) begin
        if (!resetn) begin
            de_valid <= 1'b0;
        end
        else if (i_fetch_valid && ex_ready) begin
            de_valid <= 1'b1;
        end
        // Taken by execute with nothing new behind it
        else if (ex_ready) begin
            de_valid <= 1'b0;
        end
    end

    always_ff @(posedge clk) begin
        if (i_fetch_valid && ex_ready) begin
            de_decoded <= fetch_decoded;
        end
    end

    // Source reads for the instruction held in DE
    reg_file reg_file_inst (
        .clk       (clk),
        .resetn    (resetn),
        .i_ra      (de_decoded.rs1),
        .i_rb      (de_decoded.rs2),
        .o_ra_data (rs1_data),
        .o_rb_data (rs2_data),
        .i_wb      (wb)
    );

    exec_pipeline exec_inst (
        .clk        (clk),
        .resetn     (resetn),
        .i_de_valid (de_valid),
        .i_decoded  (de_decoded),
        .i_rs1_data (rs1_data),
        .i_rs2_data (rs2_data),
        .o_ex_ready (ex_ready),
        .o_wb       (wb),
        .o_redirect (o_redirect)
    );

    assign o_wb = wb;

endmodule

`default_nettype wire

// File: hdl/core_pkg.sv
`default_nettype none
`include "core_settings.svh"

package core_pkg;

    // Major opcodes
    localparam logic [6:0] OP_REG    = 7'b0110011;
    localparam logic [6:0] OP_IMM    = 7'b0010011;
    localparam logic [6:0] OP_BRANCH = 7'b1100011;

    // funct3 of register and immediate operations
    localparam logic [2:0] F3_ADD  = 3'b000;
    localparam logic [2:0] F3_SLT  = 3'b010;
    localparam logic [2:0] F3_SLTU = 3'b011;
    localparam logic [2:0] F3_XOR  = 3'b100;
    localparam logic [2:0] F3_OR   = 3'b110;
    localparam logic [2:0] F3_AND  = 3'b111;

    // funct3 of branches
    localparam logic [2:0] F3_BEQ  = 3'b000;
    localparam logic [2:0] F3_BNE  = 3'b001;
    localparam logic [2:0] F3_BLT  = 3'b100;
    localparam logic [2:0] F3_BGEU = 3'b111;

    localparam logic [6:0] F7_SUB = 7'b0100000;
    localparam logic [6:0] F7_MUL = 7'b0000001;

    typedef struct packed {
        logic [`XLEN-1:0]   pc;
        logic [`INSN_W-1:0] insn;
    } fetch_t;

    typedef struct packed {
        logic [6:0]             funct7;
        logic [`REG_ADDR_W-1:0] rs2;
        logic [`REG_ADDR_W-1:0] rs1;
        logic [2:0]             funct3;
        logic [`REG_ADDR_W-1:0] rd;
        logic [6:0]             opcode;
    } r_fmt_t;

    typedef struct packed {
        logic [11:0]            imm;
        logic [`REG_ADDR_W-1:0] rs1;
        logic [2:0]             funct3;
        logic [`REG_ADDR_W-1:0] rd;
        logic [6:0]             opcode;
    } i_fmt_t;

    // Branch offset is scattered over the word with bit 0 implied zero
    typedef struct packed {
        logic                   imm12;
        logic [5:0]             imm10_5;
        logic [`REG_ADDR_W-1:0] rs2;
        logic [`REG_ADDR_W-1:0] rs1;
        logic [2:0]             funct3;
        logic [3:0]             imm4_1;
        logic                   imm11;
        logic [6:0]             opcode;
    } b_fmt_t;

    typedef union packed {
        r_fmt_t r;
        i_fmt_t i;
        b_fmt_t b;
    } insn_word_u;

    typedef enum logic [2:0] {
        ALU_ADD,
        ALU_SUB,
        ALU_AND,
        ALU_OR,
        ALU_XOR,
        ALU_SLT,
        ALU_SLTU
    } alu_op_e;

    typedef enum logic [1:0] {
        COND_EQ,
        COND_NE,
        COND_LT,
        COND_GEU
    } cond_e;

    typedef enum logic {
        FU_ALU,
        FU_MUL
    } unit_e;

    typedef struct packed {
        logic [`XLEN-1:0]       pc;
        logic [`REG_ADDR_W-1:0] rs1;
        logic [`REG_ADDR_W-1:0] rs2;
        logic [`REG_ADDR_W-1:0] rd;
        logic [`XLEN-1:0]       immediate;
        logic                   use_imm;
        logic                   is_branch;
        cond_e                  cond;
        alu_op_e                alu_op;
        unit_e                  unit;
    } decoded_t;

    // One in-flight stage as seen by operand forwarding
    typedef struct packed {
        logic                   pending;
        logic [`REG_ADDR_W-1:0] rd;
        logic                   data_valid;
        logic [`XLEN-1:0]       data;
    } fwd_t;

    typedef struct packed {
        logic                   valid;
        logic [`XLEN-1:0]       pc;
        logic [`REG_ADDR_W-1:0] rd;
        logic [`XLEN-1:0]       data;
    } wb_t;

    typedef struct packed {
        logic             valid;
        logic [`XLEN-1:0] pc;
    } redirect_t;

endpackage

`default_nettype wire

// File: hdl/core_settings.svh
`ifndef CORE_SETTINGS_SVH
`define CORE_SETTINGS_SVH

// Datapath and register index widths
`define XLEN        64
`define REG_ADDR_W  5
`define INSN_W      32

// First PC expected after reset
`define RESET_PC    64'h0000_0000_0000_0000

// Cycles from multiplier start to result
`define MUL_LATENCY 3

`endif

// File: hdl/exec_pipeline.sv
`timescale 1ns/1ns
`default_nettype none
`include "core_settings.svh"

module exec_pipeline import core_pkg::*; (
    input  logic             clk,
    input  logic             resetn,
    input  logic             i_de_valid,
    input  decoded_t         i_decoded,
    input  logic [`XLEN-1:0] i_rs1_data,
    input  logic [`XLEN-1:0] i_rs2_data,
    output logic             o_ex_ready,
    output wb_t              o_wb,
    output redirect_t        o_redirect
);

    typedef enum logic {
        ST_NORMAL,
        ST_MISPREDICT
    } state_e;

    state_e                 state;
    logic [`XLEN-1:0]       expected_pc;

    logic                   ex1_pending;
    unit_e                  ex1_select;
    logic [`REG_ADDR_W-1:0] ex1_rd;
    logic [`XLEN-1:0]       ex1_pc;
    logic [`XLEN-1:0]       ex1_alu_data;
    logic                   ex1_data_valid;
    logic [`XLEN-1:0]       ex1_data;
    logic                   ex1_ready;

    logic                   ex2_pending;
    unit_e                  ex2_select;
    logic [`REG_ADDR_W-1:0] ex2_rd;
    logic [`XLEN-1:0]       ex2_pc;
    logic [`XLEN-1:0]       ex2_alu_data;
    logic                   ex2_data_valid;
    logic [`XLEN-1:0]       ex2_data;
    logic                   ex2_ready;

    fwd_t                   ex1_fwd;
    fwd_t                   ex2_fwd;
    logic [`XLEN-1:0]       rs1_val;
    logic [`XLEN-1:0]       rs2_val;
    logic [`XLEN-1:0]       operand_b;
    logic [`XLEN-1:0]       alu_result;
    logic [`XLEN-1:0]       npc;
    logic [`XLEN-1:0]       branch_target;
    logic                   stalled;
    logic                   taken;
    logic                   mul_wait;
    logic                   handshake;
    logic                   can_issue;
    logic                   issue;
    logic                   mul_ready;
    logic                   mul_valid;
    logic [`XLEN-1:0]       mul_data;

    ////////////////////////////////////////
    // Operands and execute
    ////////////////////////////////////////

    assign ex1_fwd = '{pending: ex1_pending, rd: ex1_rd,
                       data_valid: ex1_data_valid, data: ex1_data};
    assign ex2_fwd = '{pending: ex2_pending, rd: ex2_rd,
                       data_valid: ex2_data_valid, data: ex2_data};

    operand_bypass bypass_inst (
        .i_rs1      (i_decoded.rs1),
        .i_rs2      (i_decoded.rs2),
        .i_rs1_data (i_rs1_data),
        .i_rs2_data (i_rs2_data),
        .i_ex1      (ex1_fwd),
        .i_ex2      (ex2_fwd),
        .o_rs1      (rs1_val),
        .o_rs2      (rs2_val),
        .o_stall    (stalled)
    );

    assign operand_b = i_decoded.use_imm ? i_decoded.immediate : rs2_val;

    int_alu alu_inst (
        .i_op     (i_decoded.alu_op),
        .i_cond   (i_decoded.cond),
        .i_a      (rs1_val),
        .i_b      (operand_b),
        .o_result (alu_result),
        .o_taken  (taken)
    );

    assign npc           = i_decoded.pc + `XLEN'(4);
    assign branch_target = i_decoded.pc + i_decoded.immediate;

    mul_unit mul_inst (
        .clk     (clk),
        .resetn  (resetn),
        .i_start (issue && i_decoded.unit == FU_MUL),
        .i_a     (rs1_val),
        .i_b     (rs2_val),
        .o_ready (mul_ready),
        .o_valid (mul_valid),
        .o_value (mul_data)
    );

    ////////////////////////////////////////
    // Issue control and branch resolution
    ////////////////////////////////////////

    assign mul_wait   = i_decoded.unit == FU_MUL && !mul_ready;
    assign o_ex_ready = ex1_ready && !(i_de_valid && (stalled || mul_wait));
    assign handshake  = i_de_valid && o_ex_ready;
    assign can_issue  = i_decoded.pc == expected_pc;
    assign issue      = handshake && can_issue;

    // Only the first wrong-path instruction raises a redirect
    assign o_redirect = '{valid: state == ST_NORMAL && handshake && !can_issue,
                          pc: expected_pc};

    always_ff @(posedge clk or negedge resetn) begin
        if (!resetn) begin
            state       <= ST_NORMAL;
            expected_pc <= `RESET_PC;
        end
        else if (handshake) begin
            state <= can_issue ? ST_NORMAL : ST_MISPREDICT;
            if (can_issue) begin
                expected_pc <= (i_decoded.is_branch && taken) ? branch_target : npc;
            end
        end
    end

    ////////////////////////////////////////
    // EX1 and EX2
    ////////////////////////////////////////

    assign ex2_ready = !ex2_pending || ex2_data_valid;
    assign ex1_ready = ex2_ready || !ex1_pending;

    always_comb begin
        if (ex1_select == FU_MUL) begin
            // Valid belongs to EX2 while EX2 also waits on the multiplier
            ex1_data_valid = mul_valid && ex2_select != FU_MUL;
            ex1_data       = mul_data;
        end
        else begin
            ex1_data_valid = 1'b1;
            ex1_data       = ex1_alu_data;
        end

        if (ex2_select == FU_MUL) begin
            ex2_data_valid = mul_valid;
            ex2_data       = mul_data;
        end
        else begin
            ex2_data_valid = 1'b1;
            ex2_data       = ex2_alu_data;
        end
    end

    always_ff @(posedge clk or negedge resetn) begin
        if (!resetn) begin
            ex1_pending <= 1'b0;
            ex1_select  <= FU_ALU;
            ex2_pending <= 1'b0;
            ex2_select  <= FU_ALU;
        end
        else begin
            // Early result is folded into the ALU data register
            if (ex1_data_valid || ex2_ready) begin
                ex1_select <= FU_ALU;
            end
            if (ex2_ready) begin
                ex1_pending <= 1'b0;
            end
            if (issue) begin
                ex1_pending <= 1'b1;
                ex1_select  <= i_decoded.unit;
            end

            if (ex2_data_valid) begin
                ex2_pending <= 1'b0;
                ex2_select  <= FU_ALU;
            end
            if (ex1_pending && ex2_ready) begin
                ex2_pending <= 1'b1;
                ex2_select  <= ex1_data_valid ? FU_ALU : ex1_select;
            end
        end
    end

    always_ff @(posedge clk) begin
        if (ex1_data_valid) begin
            ex1_alu_data <= ex1_data;
        end
        if (issue) begin
            ex1_pc       <= i_decoded.pc;
            ex1_rd       <= i_decoded.rd;
            ex1_alu_data <= i_decoded.is_branch ? npc : alu_result;
        end

        if (ex1_pending && ex2_ready) begin
            ex2_pc       <= ex1_pc;
            ex2_rd       <= ex1_rd;
            ex2_alu_data <= ex1_data;
        end
    end

    // Commit
    assign o_wb = '{valid: ex2_pending && ex2_data_valid, pc: ex2_pc,
                    rd: ex2_rd, data: ex2_data};

endmodule

`default_nettype wire

// File: hdl/insn_decoder.sv
`timescale 1ns/1ns
`default_nettype none
`include "core_settings.svh"

module insn_decoder import core_pkg::*; (
    input  fetch_t   i_fetch,
    output decoded_t o_decoded
);

    insn_word_u word;

    assign word = i_fetch.insn;

    always_comb begin
        o_decoded           = '0;
        o_decoded.pc        = i_fetch.pc;
        o_decoded.rs1       = word.r.rs1;
        o_decoded.rs2       = word.r.rs2;
        o_decoded.rd        = word.r.rd;
        o_decoded.alu_op    = ALU_ADD;
        o_decoded.cond      = COND_EQ;
        o_decoded.unit      = FU_ALU;

        unique case (word.r.opcode)
            OP_REG: begin
                if (word.r.funct7 == F7_MUL) begin
                    o_decoded.unit = FU_MUL;
                end
                else begin
                    unique case (word.r.funct3)
                        F3_ADD:  o_decoded.alu_op = (word.r.funct7 == F7_SUB) ? ALU_SUB : ALU_ADD;
                        F3_SLT:  o_decoded.alu_op = ALU_SLT;
                        F3_SLTU: o_decoded.alu_op = ALU_SLTU;
                        F3_XOR:  o_decoded.alu_op = ALU_XOR;
                        F3_OR:   o_decoded.alu_op = ALU_OR;
                        F3_AND:  o_decoded.alu_op = ALU_AND;
                        default: o_decoded.alu_op = ALU_ADD;
                    endcase
                end
            end
            OP_BRANCH: begin
                // No destination since the rd slot carries offset bits
                o_decoded.rd        = '0;
                o_decoded.is_branch = 1'b1;
                o_decoded.immediate = {{(`XLEN-12){word.b.imm12}}, word.b.imm11,
                                       word.b.imm10_5, word.b.imm4_1, 1'b0};
                unique case (word.b.funct3)
                    F3_BNE:  o_decoded.cond = COND_NE;
                    F3_BLT:  o_decoded.cond = COND_LT;
                    F3_BGEU: o_decoded.cond = COND_GEU;
                    default: o_decoded.cond = COND_EQ;
                endcase
            end
            default: begin
                // Unknown opcodes become ADDI to x0
                o_decoded.rs2       = '0;
                o_decoded.use_imm   = 1'b1;
                o_decoded.immediate = {{(`XLEN-12){word.i.imm[11]}}, word.i.imm};
                if (word.i.opcode != OP_IMM) begin
                    o_decoded.rd = '0;
                end
            end
        endcase
    end

endmodule

`default_nettype wire

// File: hdl/int_alu.sv
`timescale 1ns/1ns
`default_nettype none
`include "core_settings.svh"

module int_alu import core_pkg::*; (
    input  alu_op_e          i_op,
    input  cond_e            i_cond,
    input  logic [`XLEN-1:0] i_a,
    input  logic [`XLEN-1:0] i_b,
    output logic [`XLEN-1:0] o_result,
    output logic             o_taken
);

    // Top bit of the difference is the unsigned borrow
    logic [`XLEN:0]   diff;
    logic [`XLEN-1:0] sum;
    logic             lt_s;
    logic             lt_u;
    logic             eq;

    assign sum  = i_a + i_b;
    assign diff = {1'b0, i_a} - {1'b0, i_b};
    assign lt_u = diff[`XLEN];
    assign eq   = diff[`XLEN-1:0] == '0;

    // The difference sign decides unless the operand signs differ
    assign lt_s = (i_a[`XLEN-1] != i_b[`XLEN-1]) ? i_a[`XLEN-1] : diff[`XLEN-1];

    always_comb begin
        unique case (i_op)
            ALU_SUB:  o_result = diff[`XLEN-1:0];
            ALU_AND:  o_result = i_a & i_b;
            ALU_OR:   o_result = i_a | i_b;
            ALU_XOR:  o_result = i_a ^ i_b;
            ALU_SLT:  o_result = {{(`XLEN-1){1'b0}}, lt_s};
            ALU_SLTU: o_result = {{(`XLEN-1){1'b0}}, lt_u};
            default:  o_result = sum;
        endcase
    end

    // Branch outcome
    always_comb begin
        unique case (i_cond)
            COND_NE:  o_taken = !eq;
            COND_LT:  o_taken = lt_s;
            COND_GEU: o_taken = !lt_u;
            default:  o_taken = eq;
        endcase
    end

endmodule

`default_nettype wire

// File: hdl/mul_unit.sv
`timescale 1ns/1ns
`default_nettype none
`include "core_settings.svh"

module mul_unit (
    input  logic             clk,
    input  logic             resetn,
    input  logic             i_start,
    input  logic [`XLEN-1:0] i_a,
    input  logic [`XLEN-1:0] i_b,
    output logic             o_ready,
    output logic             o_valid,
    output logic [`XLEN-1:0] o_value
);

    localparam int CNT_W = $clog2(`MUL_LATENCY + 1);

    logic [CNT_W-1:0] count;
    logic [`XLEN-1:0] a_q;
    logic [`XLEN-1:0] b_q;

    assign o_ready = count == '0;

    // Result valid holds until the next start
    always_ff @(posedge clk or negedge resetn) begin
        if (!resetn) begin
            count   <= '0;
            o_valid <= 1'b0;
        end
        else if (i_start) begin
            count   <= CNT_W'(`MUL_LATENCY);
            o_valid <= 1'b0;
        end
        else if (count != '0) begin
            count <= count - CNT_W'(1);
            if (count == CNT_W'(1)) begin
                o_valid <= 1'b1;
            end
        end
    end

    // Low half of the product only
    always_ff @(posedge clk) begin
        if (i_start) begin
            a_q <= i_a;
            b_q <= i_b;
        end
        if (count == CNT_W'(1)) begin
            o_value <= a_q * b_q;
        end
    end

endmodule

`default_nettype wire

// File: hdl/operand_bypass.sv
`timescale 1ns/1ns
`default_nettype none
`include "core_settings.svh"

module operand_bypass import core_pkg::*; (
    input  logic [`REG_ADDR_W-1:0] i_rs1,
    input  logic [`REG_ADDR_W-1:0] i_rs2,
    input  logic [`XLEN-1:0]       i_rs1_data,
    input  logic [`XLEN-1:0]       i_rs2_data,
    input  fwd_t                   i_ex1,
    input  fwd_t                   i_ex2,
    output logic [`XLEN-1:0]       o_rs1,
    output logic [`XLEN-1:0]       o_rs2,
    output logic                   o_stall
);

    logic rs1_stall;
    logic rs2_stall;

    // Returns {stall, value}
    // EX1 holds the younger result so it wins
    function automatic logic [`XLEN:0] bypass(
        input logic [`REG_ADDR_W-1:0] rs,
        input logic [`XLEN-1:0]       rf_data,
        input fwd_t                   ex1,
        input fwd_t                   ex2
    );
        logic [`XLEN:0] res;
        res = {1'b0, rf_data};
        if (rs != '0 && ex1.pending && ex1.rd == rs) begin
            res = {!ex1.data_valid, ex1.data};
        end
        else if (rs != '0 && ex2.pending && ex2.rd == rs) begin
            res = {!ex2.data_valid, ex2.data};
        end
        return res;
    endfunction

    assign {rs1_stall, o_rs1} = bypass(i_rs1, i_rs1_data, i_ex1, i_ex2);
    assign {rs2_stall, o_rs2} = bypass(i_rs2, i_rs2_data, i_ex1, i_ex2);

    assign o_stall = rs1_stall || rs2_stall;

endmodule

`default_nettype wire

// File: hdl/reg_file.sv
`timescale 1ns/1ns
`default_nettype none
`include "core_settings.svh"

module reg_file import core_pkg::*; (
    input  logic                   clk,
    input  logic                   resetn,
    input  logic [`REG_ADDR_W-1:0] i_ra,
    input  logic [`REG_ADDR_W-1:0] i_rb,
    output logic [`XLEN-1:0]       o_ra_data,
    output logic [`XLEN-1:0]       o_rb_data,
    input  wb_t                    i_wb
);

    localparam int NREGS = 1 << `REG_ADDR_W;

    logic [`XLEN-1:0] regs [NREGS];

    always_ff @(posedge clk or negedge resetn) begin
        if (!resetn) begin
            for (int i = 0; i < NREGS; i++) begin
                regs[i] <= '0;
            end
        end
        else if (i_wb.valid && i_wb.rd != '0) begin
            regs[i_wb.rd] <= i_wb.data;
        end
    end

    // x0 is hardwired
    assign o_ra_data = (i_ra == '0) ? '0 : regs[i_ra];
    assign o_rb_data = (i_rb == '0) ? '0 : regs[i_rb];

endmodule

`default_nettype wire

// File: test/core_model.svh
`ifndef CORE_MODEL_SVH
`define CORE_MODEL_SVH

localparam int MAX_LEN = 64;

typedef enum int {
    K_ADD, K_SUB, K_AND, K_OR, K_XOR, K_SLT, K_SLTU, K_MUL,
    K_ADDI, K_BEQ, K_BNE, K_BLT, K_BGEU
} kind_e;

// Program as generated with one entry per word
kind_e                  prog_kind [MAX_LEN];
logic [`REG_ADDR_W-1:0] prog_rd   [MAX_LEN];
logic [`REG_ADDR_W-1:0] prog_rs1  [MAX_LEN];
logic [`REG_ADDR_W-1:0] prog_rs2  [MAX_LEN];
logic [`XLEN-1:0]       prog_imm  [MAX_LEN];
logic [`INSN_W-1:0]     prog_word [MAX_LEN];
int                     prog_len;
logic [`REG_ADDR_W-1:0] recent    [4];

wb_t                    exp_commits [$];
logic [`XLEN-1:0]       exp_redirects [$];

function automatic int unsigned rand_below(input int unsigned n);
    int unsigned r;
    r = $random(seed);
    return r % n;
endfunction

// Sources lean toward registers written a few instructions ago
function automatic logic [`REG_ADDR_W-1:0] pick_src();
    if (rand_below(10) < 6) begin
        return recent[rand_below(4)];
    end
    return `REG_ADDR_W'(rand_below(32));
endfunction

function automatic logic [`INSN_W-1:0] encode(
    input kind_e                  k,
    input logic [`REG_ADDR_W-1:0] rd,
    input logic [`REG_ADDR_W-1:0] rs1,
    input logic [`REG_ADDR_W-1:0] rs2,
    input logic [`XLEN-1:0]       imm
);
    insn_word_u w;
    logic [2:0] f3;
    logic [6:0] f7;
    unique case (k)
        K_SLT:   f3 = F3_SLT;
        K_SLTU:  f3 = F3_SLTU;
        K_XOR:   f3 = F3_XOR;
        K_OR:    f3 = F3_OR;
        K_AND:   f3 = F3_AND;
        K_BEQ:   f3 = F3_BEQ;
        K_BNE:   f3 = F3_BNE;
        K_BLT:   f3 = F3_BLT;
        K_BGEU:  f3 = F3_BGEU;
        default: f3 = F3_ADD;   // ADD, SUB, MUL and ADDI
    endcase
    f7 = (k == K_SUB) ? F7_SUB : (k == K_MUL) ? F7_MUL : 7'b0;
    w = '0;
    if (k == K_ADDI) begin
        w.i.opcode = OP_IMM;
        w.i.rd     = rd;
        w.i.funct3 = f3;
        w.i.rs1    = rs1;
        w.i.imm    = imm[11:0];
    end
    else if (k >= K_BEQ) begin
        w.b.opcode  = OP_BRANCH;
        w.b.funct3  = f3;
        w.b.rs1     = rs1;
        w.b.rs2     = rs2;
        w.b.imm12   = imm[12];
        w.b.imm11   = imm[11];
        w.b.imm10_5 = imm[10:5];
        w.b.imm4_1  = imm[4:1];
    end
    else begin
        w.r.opcode = OP_REG;
        w.r.rd     = rd;
        w.r.funct3 = f3;
        w.r.rs1    = rs1;
        w.r.rs2    = rs2;
        w.r.funct7 = f7;
    end
    return w;
endfunction

// Mode 0 random ALU, 1 dependent chains, 2 MUL heavy, 3 with branches
function automatic void gen_program(input int len, input int mode);
    int unsigned            r;
    int                     span;
    int                     target;
    int                     addi_cut;
    kind_e                  k;
    logic [`REG_ADDR_W-1:0] rd;
    logic [`REG_ADDR_W-1:0] rs1;
    logic [`REG_ADDR_W-1:0] rs2;
    logic [11:0]            imm12;
    logic [`XLEN-1:0]       imm;
    prog_len = len;
    addi_cut = (mode == 0) ? 30 : (mode == 1) ? 40 : 70;
    for (int j = 0; j < 4; j++) begin
        recent[j] = '0;
    end
    for (int i = 0; i < len; i++) begin
        r     = rand_below(100);
        rd    = `REG_ADDR_W'(rand_below(32));
        rs1   = pick_src();
        rs2   = pick_src();
        imm12 = 12'(rand_below(4096));
        imm   = {{(`XLEN-12){imm12[11]}}, imm12};
        if (i < 6) begin
            // Prelude seeds registers with immediates
            k   = K_ADDI;
            rd  = `REG_ADDR_W'(rand_below(31) + 1);
            rs1 = '0;
        end
        else if (mode == 3 && r < 30 && i <= len - 4) begin
            // Target at least three words ahead and still inside the program
            k      = kind_e'(int'(K_BEQ) + int'(rand_below(4)));
            span   = (len - i - 3 < 4) ? len - i - 3 : 4;
            target = i + 3 + int'(rand_below(span));
            imm    = `XLEN'((target - i) * 4);
            rd     = '0;
            if ((k == K_BEQ || k == K_BGEU) && rand_below(10) < 4) begin
                rs2 = rs1;
            end
        end
        else if (mode >= 2 && r < 55) begin
            k = K_MUL;
        end
        else if (r < addi_cut) begin
            k = K_ADDI;
        end
        else begin
            k = kind_e'(rand_below(7));
        end
        if (mode == 1 && i >= 6) begin
            rs1 = recent[0];
            if (rand_below(4) == 0) begin
                rd = '0;
            end
        end
        if (k < K_BEQ) begin
            recent[3] = recent[2];
            recent[2] = recent[1];
            recent[1] = recent[0];
            recent[0] = rd;
        end
        prog_kind[i] = k;
        prog_rd[i]   = rd;
        prog_rs1[i]  = rs1;
        prog_rs2[i]  = rs2;
        prog_imm[i]  = imm;
        prog_word[i] = encode(k, rd, rs1, rs2, imm);
    end
endfunction

// In-order ISA execution that fills the expected commit and redirect queues
function automatic void run_model();
    logic [`XLEN-1:0] regs [32];
    logic [`XLEN-1:0] pc;
    logic [`XLEN-1:0] next_pc;
    logic [`XLEN-1:0] a;
    logic [`XLEN-1:0] b;
    logic [`XLEN-1:0] res;
    logic             take;
    int               idx;
    wb_t              c;
    exp_commits.delete();
    exp_redirects.delete();
    for (int j = 0; j < 32; j++) begin
        regs[j] = '0;
    end
    pc = `RESET_PC;
    while (pc < `RESET_PC + 64'(prog_len) * 64'd4) begin
        idx  = int'((pc - `RESET_PC) >> 2);
        a    = regs[prog_rs1[idx]];
        b    = regs[prog_rs2[idx]];
        take = 1'b0;
        res  = '0;
        case (prog_kind[idx])
            K_ADD:   res = a + b;
            K_SUB:   res = a - b;
            K_AND:   res = a & b;
            K_OR:    res = a | b;
            K_XOR:   res = a ^ b;
            K_SLT:   res = ($signed(a) < $signed(b)) ? 64'd1 : 64'd0;
            K_SLTU:  res = (a < b) ? 64'd1 : 64'd0;
            K_MUL:   res = a * b;
            K_ADDI:  res = a + prog_imm[idx];
            K_BEQ:   take = a == b;
            K_BNE:   take = a != b;
            K_BLT:   take = $signed(a) < $signed(b);
            default: take = a >= b;
        endcase
        next_pc = take ? pc + prog_imm[idx] : pc + 64'd4;
        if (prog_kind[idx] >= K_BEQ) begin
            res = pc + 64'd4;
        end
        else if (prog_rd[idx] != '0) begin
            regs[prog_rd[idx]] = res;
        end
        c.valid = 1'b1;
        c.pc    = pc;
        c.rd    = prog_rd[idx];
        c.data  = res;
        exp_commits.push_back(c);
        if (take) begin
            exp_redirects.push_back(next_pc);
        end
        pc = next_pc;
    end
endfunction

`endif

// File: test/tb_core.sv
`timescale 1ns/1ns
`default_nettype none
`include "core_settings.svh"

module tb_core import core_pkg::*; ();

    localparam int HALF_PERIOD = 20;
    localparam int RUN_TIMEOUT = 4000;

    logic      clk;
    logic      resetn;
    logic      fetch_valid;
    fetch_t    fetch;
    logic      fetch_ready;
    wb_t       wb;
    redirect_t redirect;

    integer    seed = 32'h86a8735c;
    string     test_name;

    `include "core_model.svh"

    core core_inst (
        .clk           (clk),
        .resetn        (resetn),
        .i_fetch_valid (fetch_valid),
        .i_fetch       (fetch),
        .o_fetch_ready (fetch_ready),
        .o_wb          (wb),
        .o_redirect    (redirect)
    );

    initial begin
        clk = 1'b0;
        forever #HALF_PERIOD clk = ~clk;
    end

    ////////////////////////////////////////
    // Checking helpers
    ////////////////////////////////////////

    task automatic check_value(input string what, input logic [`XLEN-1:0] expected,
                               input logic [`XLEN-1:0] actual);
        if (expected !== actual) begin
            $display("ERR %s %s: expected %h, actual %h", test_name, what, expected, actual);
            $display("Test failed");
            $fatal(1, "Mismatch on %s", what);
        end
    endtask

    task automatic abort_run(input string reason);
        $display("%s in %s", reason, test_name);
        $display("Test failed");
        $fatal(1, "%s", reason);
    endtask

    task automatic apply_reset();
        @(negedge clk);
        resetn      = 1'b0;
        fetch_valid = 1'b0;
        repeat (3) @(negedge clk);
        resetn = 1'b1;
    endtask

    ////////////////////////////////////////
    // Fetch driver and commit checker
    ////////////////////////////////////////

    task automatic run_program(input string name);
        logic [`XLEN-1:0] fetch_pc;
        logic [`XLEN-1:0] end_pc;
        logic             accepted;
        logic             started;
        int               commits;
        int               total;
        int               cycles;
        int               idx;
        wb_t              exp;
        test_name = name;
        run_model();
        total    = exp_commits.size();
        end_pc   = `RESET_PC + 64'(prog_len) * 64'd4;
        apply_reset();
        fetch_pc = `RESET_PC;
        accepted = 1'b0;
        started  = 1'b0;
        commits  = 0;
        cycles   = 0;
        while (commits < total) begin
            @(negedge clk);
            // An offered word stays put until the core takes it
            if (!(fetch_valid && !accepted)) begin
                if (fetch_pc < end_pc && rand_below(4) != 0) begin
                    idx         = int'((fetch_pc - `RESET_PC) >> 2);
                    fetch_valid = 1'b1;
                    fetch.pc    = fetch_pc;
                    fetch.insn  = prog_word[idx];
                end
                else begin
                    fetch_valid = 1'b0;
                end
            end
            #1;
            accepted = fetch_valid && fetch_ready;
            if (!started) begin
                check_value("wb valid before first fetch", 64'd0, 64'(wb.valid));
                check_value("redirect before first fetch", 64'd0, 64'(redirect.valid));
            end
            if (wb.valid) begin
                exp = exp_commits.pop_front();
                check_value("commit pc", exp.pc, wb.pc);
                check_value("commit rd", 64'(exp.rd), 64'(wb.rd));
                check_value("commit data", exp.data, wb.data);
                commits++;
            end
            // Redirect wins over the sequential next PC
            if (redirect.valid) begin
                if (exp_redirects.size() == 0) begin
                    abort_run("Redirect raised where no branch was taken");
                end
                else begin
                    check_value("redirect target", exp_redirects.pop_front(), redirect.pc);
                    fetch_pc = redirect.pc;
                end
            end
            else if (accepted) begin
                fetch_pc = fetch_pc + 64'd4;
            end
            started = started || accepted;
            cycles++;
            if (cycles > RUN_TIMEOUT) begin
                abort_run($sformatf("Timeout with %0d of %0d commits seen", commits, total));
            end
        end
        check_value("redirects left", 64'd0, 64'(exp_redirects.size()));
        // Nothing may commit once the program is done
        repeat (8) begin
            @(negedge clk);
            fetch_valid = 1'b0;
            #1;
            check_value("commit after end", 64'd0, 64'(wb.valid));
            check_value("redirect after end", 64'd0, 64'(redirect.valid));
        end
    endtask

    ////////////////////////////////////////
    // Test sequence
    ////////////////////////////////////////

    initial begin
        resetn      = 1'b0;
        fetch_valid = 1'b0;
        fetch       = '0;
        test_name   = "";
        for (int round = 0; round < 2; round++) begin
            gen_program(40, 0);
            run_program("alu_random");
            gen_program(40, 1);
            run_program("dep_chains");
            gen_program(32, 2);
            run_program("mul_chains");
            gen_program(48, 3);
            run_program("branches");
        end
        $display("Test passed");
        $finish;
    end

endmodule

`default_nettype wire

// File: verilog.f
+incdir+hdl
+incdir+test
hdl/core_pkg.sv
hdl/insn_decoder.sv
hdl/operand_bypass.sv
hdl/int_alu.sv
hdl/mul_unit.sv
hdl/reg_file.sv
hdl/exec_pipeline.sv
hdl/core.sv
test/tb_core.sv
